// File: src/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:2]     pc_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [11:0]     csr_idx_t;
    typedef logic [1:0]      res_src_t;
    // top bit is the arithmetic shift flag
    typedef logic [4:0]      alu_ctrl_t;

    // opcode bits 6:2, low pair must be 2'b11
    localparam logic [4:0] GRP_LOAD     = 5'b00000;
    localparam logic [4:0] GRP_MISC_MEM = 5'b00011;
    localparam logic [4:0] GRP_OP_IMM   = 5'b00100;
    localparam logic [4:0] GRP_AUIPC    = 5'b00101;
    localparam logic [4:0] GRP_STORE    = 5'b01000;
    localparam logic [4:0] GRP_OP       = 5'b01100;
    localparam logic [4:0] GRP_LUI      = 5'b01101;
    localparam logic [4:0] GRP_BRANCH   = 5'b11000;
    localparam logic [4:0] GRP_JALR     = 5'b11001;
    localparam logic [4:0] GRP_JAL      = 5'b11011;
    localparam logic [4:0] GRP_SYSTEM   = 5'b11100;

    // alu operation, lower four bits of alu_ctrl_t
    localparam logic [3:0] ALU_ADD      = 4'd0;
    localparam logic [3:0] ALU_SUB      = 4'd1;
    localparam logic [3:0] ALU_XOR      = 4'd2;
    localparam logic [3:0] ALU_OR       = 4'd3;
    localparam logic [3:0] ALU_AND      = 4'd4;
    localparam logic [3:0] ALU_SHL      = 4'd5;
    localparam logic [3:0] ALU_SHR      = 4'd6;
    localparam logic [3:0] ALU_CMP_EQ   = 4'd8;
    localparam logic [3:0] ALU_CMP_NEQ  = 4'd9;
    localparam logic [3:0] ALU_CMP_LTS  = 4'd10;
    localparam logic [3:0] ALU_CMP_NLTS = 4'd11;
    localparam logic [3:0] ALU_CMP_LTU  = 4'd12;
    localparam logic [3:0] ALU_CMP_NLTU = 4'd13;

    localparam res_src_t RES_SRC_ALU    = 2'd0;
    localparam res_src_t RES_SRC_MEMORY = 2'd1;
    localparam res_src_t RES_SRC_PC_P4  = 2'd2;

    localparam logic OP1_SEL_REG = 1'b0;
    localparam logic OP1_SEL_PC  = 1'b1;
    localparam logic OP2_SEL_REG = 1'b0;
    localparam logic OP2_SEL_IMM = 1'b1;

endpackage

// File: src/rv_decode_if.sv
`timescale 1ns/1ps

interface rv_decode_if;

    rv_decode_pkg::word_t instr;

    // one flag per group, legal encodings only
    logic is_load;
    logic is_store;
    logic is_op_imm;
    logic is_op;
    logic is_lui;
    logic is_auipc;
    logic is_branch;
    logic is_jal;
    logic is_jalr;

    modport source
    (
        output instr,
        output is_load,
        output is_store,
        output is_op_imm,
        output is_op,
        output is_lui,
        output is_auipc,
        output is_branch,
        output is_jal,
        output is_jalr
    );

    modport sink
    (
        input instr,
        input is_load,
        input is_store,
        input is_op_imm,
        input is_op,
        input is_lui,
        input is_auipc,
        input is_branch,
        input is_jal,
        input is_jalr
    );

endinterface

// File: src/rv_fetch_latch.sv
`timescale 1ns/1ps

module rv_fetch_latch
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_stall,
    input  logic                 i_flush,
    input  rv_decode_pkg::pc_t   i_pc,
    input  rv_decode_pkg::pc_t   i_pc_p4,
    input  rv_decode_pkg::word_t i_data,
    output rv_decode_pkg::pc_t   o_pc,
    output rv_decode_pkg::pc_t   o_pc_p4,
    output rv_decode_pkg::word_t o_instr,
    output logic                 o_masked
);

    rv_decode_pkg::pc_t r_pc;
    rv_decode_pkg::pc_t r_pc_p4;
    logic               r_flush;

    // flush wins over stall
    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            r_pc    <= '0;
            r_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            r_pc    <= i_pc;
            r_pc_p4 <= i_pc_p4;
        end
    end

    // memory reply after a flush belongs to the dropped fetch
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            r_flush <= 1'b0;
        else
            r_flush <= i_flush;
    end

    assign o_masked = i_rst | r_flush;
    assign o_instr  = o_masked ? '0 : i_data;
    assign o_pc     = r_pc;
    assign o_pc_p4  = r_pc_p4;

endmodule

// File: src/rv_instr_classify.sv
`timescale 1ns/1ps

module rv_instr_classify
(
    input  rv_decode_pkg::word_t i_instr,
    input  logic                 i_masked,
    input  logic                 i_flush,
    rv_decode_if.source          dec,
    output logic                 o_inv_instr,
    output logic                 o_csr_read,
    output logic                 o_csr_write
);

    logic [4:0]               grp;
    logic                     full;
    rv_decode_pkg::funct3_t   funct3;
    logic [6:0]               funct7;
    rv_decode_pkg::reg_idx_t  rd;
    rv_decode_pkg::reg_idx_t  rs1;
    logic                     f7_zero;
    logic                     f7_alt;

    logic grp_load;
    logic grp_store;
    logic grp_op_imm;
    logic grp_op;
    logic grp_branch;
    logic grp_jalr;
    logic grp_misc_mem;
    logic grp_system;

    logic is_fence;
    logic supported;
    logic csr_rw_form;
    logic csr_sc_form;

    assign grp     = i_instr[6:2];
    assign full    = (i_instr[1:0] == 2'b11);
    assign funct3  = i_instr[14:12];
    assign funct7  = i_instr[31:25];
    assign rd      = i_instr[11:7];
    assign rs1     = i_instr[19:15];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    assign grp_load     = full & (grp == rv_decode_pkg::GRP_LOAD);
    assign grp_store    = full & (grp == rv_decode_pkg::GRP_STORE);
    assign grp_op_imm   = full & (grp == rv_decode_pkg::GRP_OP_IMM);
    assign grp_op       = full & (grp == rv_decode_pkg::GRP_OP);
    assign grp_branch   = full & (grp == rv_decode_pkg::GRP_BRANCH);
    assign grp_jalr     = full & (grp == rv_decode_pkg::GRP_JALR);
    assign grp_misc_mem = full & (grp == rv_decode_pkg::GRP_MISC_MEM);
    assign grp_system   = full & (grp == rv_decode_pkg::GRP_SYSTEM);

    assign dec.instr = i_instr;

    // lb, lh, lw, lbu, lhu
    assign dec.is_load  = grp_load & (funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
    assign dec.is_store = grp_store & (funct3 <= 3'd2);

    // only the right shifts carry a funct7 variant
    assign dec.is_op_imm = grp_op_imm & ((funct3 != 3'd5) | f7_zero | f7_alt);

    // sub and sra are the only alternate forms
    assign dec.is_op = grp_op &
                       (f7_zero | (f7_alt & ((funct3 == 3'd0) | (funct3 == 3'd5))));

    assign dec.is_lui    = full & (grp == rv_decode_pkg::GRP_LUI);
    assign dec.is_auipc  = full & (grp == rv_decode_pkg::GRP_AUIPC);
    assign dec.is_branch = grp_branch & (funct3 != 3'd2) & (funct3 != 3'd3);
    assign dec.is_jal    = full & (grp == rv_decode_pkg::GRP_JAL);
    assign dec.is_jalr   = grp_jalr & (funct3 == 3'd0);

    // fence and fence.i
    assign is_fence = grp_misc_mem & (funct3 <= 3'd1);

    // system words stay outside the supported set
    assign supported = dec.is_load | dec.is_store | dec.is_op_imm | dec.is_op |
                       dec.is_lui | dec.is_auipc | dec.is_branch | dec.is_jal |
                       dec.is_jalr | is_fence;

    assign o_inv_instr = ~supported & ~i_flush & ~i_masked;

    // csrrw/csrrwi vs csrrs/csrrc/csrrsi/csrrci
    assign csr_rw_form = (funct3[1:0] == 2'b01);
    assign csr_sc_form = funct3[1];

    assign o_csr_read  = grp_system & ((csr_rw_form & (|rd)) | csr_sc_form);
    assign o_csr_write = grp_system & (csr_rw_form | (csr_sc_form & (|rs1)));

endmodule

// File: src/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen
(
    rv_decode_if.sink            dec,
    output rv_decode_pkg::word_t o_imm
);

    rv_decode_pkg::word_t imm;
    rv_decode_pkg::word_t ins;

    assign ins = dec.instr;

    // priority follows the format table
    always_comb
    begin
        if (dec.is_jal)
        begin
            // J-type
            imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        else if (dec.is_lui || dec.is_auipc)
        begin
            imm = {ins[31:12], 12'b0};
        end
        else if (dec.is_jalr || dec.is_load || dec.is_op_imm)
        begin
            imm = {{21{ins[31]}}, ins[30:20]};
        end
        else if (dec.is_branch)
        begin
            // B-type
            imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        else if (dec.is_store)
        begin
            imm = {{21{ins[31]}}, ins[30:25], ins[11:7]};
        end
        else
        begin
            imm = '0;
        end
    end

    assign o_imm = imm;

endmodule

// File: src/rv_ctrl_gen.sv
`timescale 1ns/1ps

module rv_ctrl_gen
(
    rv_decode_if.sink                 dec,
    output rv_decode_pkg::reg_idx_t   o_rs1,
    output rv_decode_pkg::reg_idx_t   o_rs2,
    output rv_decode_pkg::reg_idx_t   o_rd,
    output rv_decode_pkg::funct3_t    o_funct3,
    output rv_decode_pkg::csr_idx_t   o_csr_idx,
    output rv_decode_pkg::alu_ctrl_t  o_alu_ctrl,
    output rv_decode_pkg::res_src_t   o_res_src,
    output logic                      o_reg_write,
    output logic                      o_mem_read,
    output logic                      o_mem_write,
    output logic                      o_jump,
    output logic                      o_branch,
    output logic                      o_pc_sel,
    output logic                      o_alu_op1_sel,
    output logic                      o_alu_op2_sel
);

    rv_decode_pkg::funct3_t funct3;
    logic                   is_arith;
    logic [3:0]             alu_op;
    logic                   arith_shift;

    assign funct3   = dec.instr[14:12];
    assign is_arith = dec.is_op_imm | dec.is_op;

    // lui has no rs1 field
    assign o_rs1     = dec.is_lui ? '0 : dec.instr[19:15];
    assign o_rs2     = dec.instr[24:20];
    assign o_rd      = dec.instr[11:7];
    assign o_funct3  = funct3;
    assign o_csr_idx = dec.instr[31:20];

    assign o_reg_write = dec.is_load | dec.is_op_imm | dec.is_op | dec.is_lui |
                         dec.is_auipc | dec.is_jal | dec.is_jalr;
    assign o_mem_read  = dec.is_load;
    assign o_mem_write = dec.is_store;
    assign o_jump      = dec.is_jal | dec.is_jalr;
    assign o_branch    = dec.is_branch;
    assign o_pc_sel    = dec.is_jalr;

    assign o_alu_op1_sel = (dec.is_auipc | dec.is_jal) ? rv_decode_pkg::OP1_SEL_PC
                                                       : rv_decode_pkg::OP1_SEL_REG;

    assign o_alu_op2_sel = (dec.is_load | dec.is_store | dec.is_op_imm | dec.is_lui |
                            dec.is_auipc | dec.is_jal | dec.is_jalr)
                           ? rv_decode_pkg::OP2_SEL_IMM : rv_decode_pkg::OP2_SEL_REG;

    always_comb
    begin
        if (dec.is_load)
            o_res_src = rv_decode_pkg::RES_SRC_MEMORY;
        else if (dec.is_jal || dec.is_jalr)
            o_res_src = rv_decode_pkg::RES_SRC_PC_P4;
        else
            o_res_src = rv_decode_pkg::RES_SRC_ALU;
    end

    always_comb
    begin
        alu_op = rv_decode_pkg::ALU_ADD;
        if (dec.is_branch)
        begin
            case (funct3)
                3'd0:    alu_op = rv_decode_pkg::ALU_CMP_EQ;
                3'd1:    alu_op = rv_decode_pkg::ALU_CMP_NEQ;
                3'd4:    alu_op = rv_decode_pkg::ALU_CMP_LTS;
                3'd5:    alu_op = rv_decode_pkg::ALU_CMP_NLTS;
                3'd6:    alu_op = rv_decode_pkg::ALU_CMP_LTU;
                3'd7:    alu_op = rv_decode_pkg::ALU_CMP_NLTU;
                default: alu_op = rv_decode_pkg::ALU_ADD;
            endcase
        end
        else if (is_arith)
        begin
            case (funct3)
                // addi never subtracts
                3'd0:    alu_op = (dec.is_op && dec.instr[30]) ? rv_decode_pkg::ALU_SUB
                                                               : rv_decode_pkg::ALU_ADD;
                3'd1:    alu_op = rv_decode_pkg::ALU_SHL;
                3'd2:    alu_op = rv_decode_pkg::ALU_CMP_LTS;
                3'd3:    alu_op = rv_decode_pkg::ALU_CMP_LTU;
                3'd4:    alu_op = rv_decode_pkg::ALU_XOR;
                3'd5:    alu_op = rv_decode_pkg::ALU_SHR;
                3'd6:    alu_op = rv_decode_pkg::ALU_OR;
                default: alu_op = rv_decode_pkg::ALU_AND;
            endcase
        end
    end

    // sra and srai
    assign arith_shift = is_arith & (funct3 == 3'd5) & dec.instr[30];
    assign o_alu_ctrl  = {arith_shift, alu_op};

endmodule

// File: src/rv_decode_top.sv
`timescale 1ns/1ps

module rv_decode_top
(
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_stall,
    input  logic                      i_flush,
    input  rv_decode_pkg::word_t      i_data,
    input  rv_decode_pkg::pc_t        i_pc,
    input  rv_decode_pkg::pc_t        i_pc_p4,
    output rv_decode_pkg::reg_idx_t   o_rs1,
    output rv_decode_pkg::reg_idx_t   o_rs2,
    output rv_decode_pkg::reg_idx_t   o_rd,
    output rv_decode_pkg::pc_t        o_pc,
    output rv_decode_pkg::pc_t        o_pc_p4,
    output rv_decode_pkg::word_t      o_imm,
    output logic                      o_reg_write,
    output logic                      o_mem_read,
    output logic                      o_mem_write,
    output rv_decode_pkg::res_src_t   o_res_src,
    output logic                      o_pc_sel,
    output logic                      o_jump,
    output logic                      o_branch,
    output logic                      o_alu_op1_sel,
    output logic                      o_alu_op2_sel,
    output rv_decode_pkg::funct3_t    o_funct3,
    output rv_decode_pkg::alu_ctrl_t  o_alu_ctrl,
    output logic                      o_inv_instr,
    output rv_decode_pkg::csr_idx_t   o_csr_idx,
    output logic                      o_csr_read,
    output logic                      o_csr_write
);

    rv_decode_pkg::word_t instr;
    logic                 masked;

    rv_decode_if dec_bus ();

    rv_fetch_latch u_fetch_latch
    (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_stall  (i_stall),
        .i_flush  (i_flush),
        .i_pc     (i_pc),
        .i_pc_p4  (i_pc_p4),
        .i_data   (i_data),
        .o_pc     (o_pc),
        .o_pc_p4  (o_pc_p4),
        .o_instr  (instr),
        .o_masked (masked)
    );

    rv_instr_classify u_classify
    (
        .i_instr     (instr),
        .i_masked    (masked),
        .i_flush     (i_flush),
        .dec         (dec_bus.source),
        .o_inv_instr (o_inv_instr),
        .o_csr_read  (o_csr_read),
        .o_csr_write (o_csr_write)
    );

    rv_imm_gen u_imm_gen
    (
        .dec   (dec_bus.sink),
        .o_imm (o_imm)
    );

    rv_ctrl_gen u_ctrl_gen
    (
        .dec           (dec_bus.sink),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_rd          (o_rd),
        .o_funct3      (o_funct3),
        .o_csr_idx     (o_csr_idx),
        .o_alu_ctrl    (o_alu_ctrl),
        .o_res_src     (o_res_src),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel)
    );

endmodule

// File: test/rv_decode_asserts.sv
`timescale 1ns/1ps

module rv_decode_asserts
(
    input logic       i_clk,
    input logic       i_flush,
    input logic       o_mem_read,
    input logic       o_mem_write,
    input logic       o_jump,
    input logic [1:0] o_res_src,
    input logic       o_pc_sel,
    input logic       o_branch,
    input logic       o_reg_write,
    input logic       o_inv_instr
);

    int fail_count = 0;

    a_mem_excl: assert property (@(posedge i_clk) !(o_mem_read && o_mem_write))
        else
        begin
            $error("memory read and write both high");
            fail_count++;
        end

    a_jump_src: assert property (@(posedge i_clk)
        o_jump |-> o_res_src == rv_decode_pkg::RES_SRC_PC_P4)
        else
        begin
            $error("jump without pc+4 result source");
            fail_count++;
        end

    a_pc_sel: assert property (@(posedge i_clk) o_pc_sel |-> o_jump)
        else
        begin
            $error("pc select without jump");
            fail_count++;
        end

    // branches never write the register file
    a_branch_wr: assert property (@(posedge i_clk) o_branch |-> !o_reg_write)
        else
        begin
            $error("branch with register write");
            fail_count++;
        end

    a_flush_inv: assert property (@(posedge i_clk) i_flush |-> !o_inv_instr)
        else
        begin
            $error("invalid flag during flush");
            fail_count++;
        end

endmodule

bind rv_decode_top rv_decode_asserts u_decode_asserts (.*);

// File: test/tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode;

    logic                      i_clk;
    logic                      i_rst;
    logic                      i_stall;
    logic                      i_flush;
    rv_decode_pkg::word_t      i_data;
    rv_decode_pkg::pc_t        i_pc;
    rv_decode_pkg::pc_t        i_pc_p4;
    rv_decode_pkg::reg_idx_t   o_rs1;
    rv_decode_pkg::reg_idx_t   o_rs2;
    rv_decode_pkg::reg_idx_t   o_rd;
    rv_decode_pkg::pc_t        o_pc;
    rv_decode_pkg::pc_t        o_pc_p4;
    rv_decode_pkg::word_t      o_imm;
    logic                      o_reg_write;
    logic                      o_mem_read;
    logic                      o_mem_write;
    rv_decode_pkg::res_src_t   o_res_src;
    logic                      o_pc_sel;
    logic                      o_jump;
    logic                      o_branch;
    logic                      o_alu_op1_sel;
    logic                      o_alu_op2_sel;
    rv_decode_pkg::funct3_t    o_funct3;
    rv_decode_pkg::alu_ctrl_t  o_alu_ctrl;
    logic                      o_inv_instr;
    rv_decode_pkg::csr_idx_t   o_csr_idx;
    logic                      o_csr_read;
    logic                      o_csr_write;

    integer seed = 6;
    int     errors = 0;
    int     tests = 0;
    int     cycles = 0;

    // expected decode, built from the instruction set rules
    logic [4:0] grp;
    logic [2:0] f3;
    logic       ok;
    logic ld, st, oi, op, lu, au, br, jl, jr, fence, sys;
    logic [7:0]           exp_ctrl;
    logic [1:0]           exp_res;
    logic [4:0]           exp_alu;
    rv_decode_pkg::word_t exp_imm;
    logic                 exp_inv;
    logic [1:0]           exp_csr;

    rv_decode_top DUT (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycles++;
        if (cycles >= 2000)
        begin
            $display("timeout: the run did not finish within 2000 cycles");
            $display("CHECKS FAILED");
            $finish;
        end
    end

    always_comb
    begin
        grp   = i_data[6:2];
        f3    = i_data[14:12];
        ok    = (i_data[1:0] == 2'b11);
        ld    = ok && grp == 5'b00000 && f3 != 3'd3 && f3 < 3'd6;
        st    = ok && grp == 5'b01000 && f3 < 3'd3;
        oi    = ok && grp == 5'b00100 && (f3 != 3'd5 || i_data[31:25] == 7'h00
                                          || i_data[31:25] == 7'h20);
        op    = ok && grp == 5'b01100 && (i_data[31:25] == 7'h00
                                          || (i_data[31:25] == 7'h20 && (f3 == 0 || f3 == 5)));
        lu    = ok && grp == 5'b01101;
        au    = ok && grp == 5'b00101;
        br    = ok && grp == 5'b11000 && f3 != 3'd2 && f3 != 3'd3;
        jl    = ok && grp == 5'b11011;
        jr    = ok && grp == 5'b11001 && f3 == 3'd0;
        fence = ok && grp == 5'b00011 && f3 < 3'd2;
        sys   = ok && grp == 5'b11100;
        exp_ctrl = {ld | oi | op | lu | au | jl | jr, ld, st, jl | jr, br, jr, au | jl,
                    ld | st | oi | lu | au | jl | jr};
        exp_res  = ld ? 2'd1 : ((jl | jr) ? 2'd2 : 2'd0);
        if (jl)
            exp_imm = {{11{i_data[31]}}, i_data[31], i_data[19:12], i_data[20],
                       i_data[30:21], 1'b0};
        else if (lu || au)
            exp_imm = {i_data[31:12], 12'h000};
        else if (jr || ld || oi)
            exp_imm = {{20{i_data[31]}}, i_data[31:20]};
        else if (br)
            exp_imm = {{19{i_data[31]}}, i_data[31], i_data[7], i_data[30:25],
                       i_data[11:8], 1'b0};
        else if (st)
            exp_imm = {{20{i_data[31]}}, i_data[31:25], i_data[11:7]};
        else
            exp_imm = '0;
        exp_alu = 5'd0;
        if (br)
            exp_alu[3:0] = (f3 < 3'd2) ? {3'b100, f3[0]} : {1'b1, f3} - 4'd2;
        else if (oi || op)
        begin
            case (f3)
                3'd0: exp_alu[3:0] = (op && i_data[30]) ? 4'd1 : 4'd0;
                3'd1: exp_alu[3:0] = 4'd5;
                3'd2: exp_alu[3:0] = 4'd10;
                3'd3: exp_alu[3:0] = 4'd12;
                3'd4: exp_alu[3:0] = 4'd2;
                3'd5: exp_alu = {i_data[30], 4'd6};
                3'd6: exp_alu[3:0] = 4'd3;
                3'd7: exp_alu[3:0] = 4'd4;
            endcase
        end
        exp_inv = !(ld | st | oi | op | lu | au | br | jl | jr | fence) && !i_flush;
        // csrrw=1 csrrs=2 csrrc=3, immediate forms add 4
        exp_csr = {sys && ((f3 == 3'd1 || f3 == 3'd5) ? i_data[11:7] != 0
                                                       : f3 inside {3'd2, 3'd3, 3'd6, 3'd7}),
                   sys && (f3 == 3'd1 || f3 == 3'd5
                           || (f3 inside {3'd2, 3'd3, 3'd6, 3'd7} && i_data[19:15] != 0))};
    end

    task automatic note_error(input string msg);
        $display("[ERROR] %0t: %s (data %h)", $time, msg, i_data);
        errors++;
    endtask

    // decode is only compared when the word reaches the decoder unmasked
    a_ctrl: assert property (@(posedge i_clk) (!i_rst && !$past(i_flush)) |->
        {o_reg_write, o_mem_read, o_mem_write, o_jump, o_branch, o_pc_sel,
         o_alu_op1_sel, o_alu_op2_sel} == exp_ctrl && o_res_src == exp_res)
        else note_error("control outputs mismatch");
    a_imm: assert property (@(posedge i_clk) (!i_rst && !$past(i_flush)) |-> o_imm == exp_imm)
        else note_error("immediate mismatch");
    a_alu: assert property (@(posedge i_clk) (!i_rst && !$past(i_flush)) |->
        o_alu_ctrl == exp_alu) else note_error("alu control mismatch");
    a_inv: assert property (@(posedge i_clk) (!i_rst && !$past(i_flush)) |->
        o_inv_instr == exp_inv && {o_csr_read, o_csr_write} == exp_csr)
        else note_error("invalid or csr flag mismatch");
    a_fields: assert property (@(posedge i_clk) (!i_rst && !$past(i_flush)) |->
        o_rs1 == (lu ? 5'd0 : i_data[19:15]) && o_rs2 == i_data[24:20]
        && o_rd == i_data[11:7] && o_funct3 == f3 && o_csr_idx == i_data[31:20])
        else note_error("register field mismatch");
    a_masked: assert property (@(posedge i_clk) (i_rst || $past(i_flush)) |->
        !(o_reg_write | o_mem_read | o_mem_write | o_jump | o_branch | o_pc_sel
          | o_alu_op1_sel | o_alu_op2_sel | o_inv_instr) && o_res_src == 2'd0
        && o_alu_ctrl == 5'd0) else note_error("outputs not cleared while masked");
    a_pc_flush: assert property (@(posedge i_clk) (cycles > 1 && $past(i_flush)) |->
        o_pc == '0 && o_pc_p4 == '0) else note_error("pc not cleared by flush");
    a_pc_load: assert property (@(posedge i_clk)
        (cycles > 1 && !$past(i_rst) && !$past(i_flush) && !$past(i_stall)) |->
        o_pc == $past(i_pc) && o_pc_p4 == $past(i_pc_p4)) else note_error("pc not loaded");
    a_pc_hold: assert property (@(posedge i_clk)
        (cycles > 1 && !$past(i_rst) && !$past(i_flush) && $past(i_stall)) |->
        $stable(o_pc) && $stable(o_pc_p4)) else note_error("pc changed during stall");

    function automatic rv_decode_pkg::word_t legal_word(input logic [4:0] g,
                                                        input rv_decode_pkg::word_t r);
        rv_decode_pkg::word_t w;
        logic [2:0]           f;
        w      = {r[31:7], g, 2'b11};
        f      = r[14:12];
        case (g)
            rv_decode_pkg::GRP_LOAD:   if (f == 3'd3 || f > 3'd5) f = 3'd2;
            rv_decode_pkg::GRP_STORE:  f = f % 3'd3;
            rv_decode_pkg::GRP_OP_IMM: if (f == 3'd5) w[31:25] = {1'b0, r[30], 5'b0};
            rv_decode_pkg::GRP_OP:     w[31:25] = (f == 0 || f == 5) ? {1'b0, r[30], 5'b0} : 7'h0;
            rv_decode_pkg::GRP_BRANCH: if (f == 3'd2 || f == 3'd3) f = f + 3'd2;
            rv_decode_pkg::GRP_JALR:   f = 3'd0;
            default:                   f = f;
        endcase
        w[14:12] = f;
        return w;
    endfunction

    task automatic drive(input rv_decode_pkg::word_t w, input logic stall, input logic flush);
        @(negedge i_clk);
        i_data  = w;
        i_stall = stall;
        i_flush = flush;
        i_pc    = $random(seed);
        i_pc_p4 = i_pc + 30'd1;
    endtask

    task automatic finish_test(input string name);
        drive(32'h0000_0013, 1'b0, 1'b0);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    initial
    begin
        logic [4:0] groups [9];
        groups = '{5'b00000, 5'b01000, 5'b00100, 5'b01100, 5'b01101,
                   5'b00101, 5'b11000, 5'b11011, 5'b11001};
        i_rst = 1'b1;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_data = '0;
        i_pc = '0;
        i_pc_p4 = '0;
        repeat (3) @(negedge i_clk);
        i_rst = 1'b0;
        for (int i = 0; i < 40; i++)
            drive(legal_word(5'b00100, $random(seed)), $random(seed), 1'b0);
        finish_test("pc pipeline");
        for (int i = 0; i < 20; i++)
            drive($random(seed), $random(seed), (i % 3) == 0);
        finish_test("flush");
        foreach (groups[g])
            for (int i = 0; i < 20; i++)
                drive(legal_word(groups[g], $random(seed)), 1'b0, 1'b0);
        finish_test("group controls");
        for (int i = 0; i < 100; i++)
            drive(legal_word(groups[i % 9], $random(seed)), 1'b0, 1'b0);
        finish_test("immediates");
        for (int f = 0; f < 8; f++)
        begin
            drive({7'h00, 10'h0a5, f[2:0], 5'd3, 7'b0110011}, 1'b0, 1'b0);
            drive({7'h20, 10'h0a5, f[2:0], 5'd3, 7'b0110011}, 1'b0, 1'b0);
            drive({7'h20, 10'h0a5, f[2:0], 5'd3, 7'b0010011}, 1'b0, 1'b0);
            drive({7'h00, 10'h0a5, f[2:0], 5'd3, 7'b1100011}, 1'b0, 1'b0);
        end
        finish_test("alu control");
        for (int i = 0; i < 250; i++)
            drive((i % 2) ? {$random(seed)} : ({$random(seed)} | 32'h73) & 32'hffff_fff3,
                  1'b0, 1'b0);
        finish_test("invalid and csr");
        repeat (2) @(negedge i_clk);
        errors += DUT.u_decode_asserts.fail_count;
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: flist.f
src/rv_decode_pkg.sv
src/rv_decode_if.sv
src/rv_fetch_latch.sv
src/rv_instr_classify.sv
src/rv_imm_gen.sv
src/rv_ctrl_gen.sv
src/rv_decode_top.sv
test/rv_decode_asserts.sv
test/tb_rv_decode.sv
